// File: rtl/cpu_dma_defs.svh
// Width definitions shared by the CPU-side DMA bus master and its sequencers
`ifndef CPU_DMA_DEFS_SVH
`define CPU_DMA_DEFS_SVH

`define CPU_DMA_CTL_STATE_W 3 // Bus controller state, five states used
`define CPU_DMA_SEQ_STATE_W 3 // Drain and fill sequencers, eight states each
`define CPU_DMA_TERM_W      2 // Termination class of one bus cycle
`define CPU_DMA_DSACK_W     2 // DSACK1 in bit 1, DSACK0 in bit 0

`endif

// File: rtl/cpu_dma_pkg.sv
// Types and termination decode shared by the CPU-side DMA bus master blocks
`include "cpu_dma_defs.svh"

package cpu_dma_pkg;

    typedef logic [`CPU_DMA_DSACK_W-1:0] dsack_t; // Active low, as seen on the bus

    typedef enum logic [`CPU_DMA_TERM_W-1:0] {
        term_none, // Cycle still running
        term_32,   // STERM or both DSACK lines
        term_16,   // DSACK1 only, 16-bit port
        term_bad   // 8-bit response, not supported
    } term_e;

    typedef enum logic [`CPU_DMA_CTL_STATE_W-1:0] {
        ctl_idle, ctl_drain_req, ctl_fill_req, ctl_own, ctl_letgo
    } ctl_state_e;

    typedef enum logic [`CPU_DMA_SEQ_STATE_W-1:0] {
        dr_idle, dr_start, dr_strobe, dr_wait,
        dr_word_start, dr_word_strobe, dr_word_wait, dr_check
    } drain_state_e;

    typedef enum logic [`CPU_DMA_SEQ_STATE_W-1:0] {
        fl_idle, fl_start, fl_strobe, fl_wait,
        fl_odd_start, fl_odd_hold, fl_odd_wait, fl_next
    } fill_state_e;

    // STERM wins over DSACK, and the DSACK pair only counts once dsack is valid
    function automatic term_e term_classify(input logic n_sterm, input logic dsack,
                                            input dsack_t n_dsack);
        term_e cls;
        if (!n_sterm) cls = term_32;               // Synchronous 32-bit termination
        else if (!dsack) cls = term_none;          // Nothing sampled yet
        else if (n_dsack == 2'b00) cls = term_32;  // Both DSACK lines low
        else if (n_dsack == 2'b01) cls = term_16;  // Only DSACK1 low
        else cls = term_bad;                       // Byte port or glitch
        return cls;
    endfunction

endpackage

// File: rtl/dma_bus_ctl.sv
// Bus controller that picks the DMA direction, owns the CPU bus and merges FIFO count requests
`timescale 1ns/1ps

module dma_bus_ctl (
    input  logic CLK90,
    input  logic nRESET,
    input  logic dma_ena,
    input  logic dma_dir,
    input  logic fifo_full,
    input  logic fifo_empty,
    input  logic n_dreq,
    input  logic n_bgrant,
    input  logic cycle_done,
    input  logic n_rififo,
    input  logic n_rdfifo,
    input  logic drain_start_ready,
    input  logic drain_done,
    input  logic drain_dec,
    input  logic fill_start_ready,
    input  logic fill_done,
    input  logic fill_inc,
    output logic breq,
    output logic bgack,
    output logic drain_start_valid,
    output logic fill_start_valid,
    output logic inc_fifo,
    output logic dec_fifo
);

    cpu_dma_pkg::ctl_state_e state;
    cpu_dma_pkg::ctl_state_e state_nxt;
    logic                    dir_drain;  // Direction latched for this bus tenure
    logic                    dispatched; // Sequencer has taken the start
    logic                    bus_won;
    logic                    seq_done;
    logic                    accept;

    assign bus_won  = !n_bgrant && cycle_done;             // Granted and previous owner is off
    assign seq_done = dir_drain ? drain_done : fill_done;  // Only the dispatched side counts
    assign drain_start_valid = (state == cpu_dma_pkg::ctl_own) && dir_drain && !dispatched;
    assign fill_start_valid  = (state == cpu_dma_pkg::ctl_own) && !dir_drain && !dispatched;
    assign accept = (drain_start_valid && drain_start_ready) ||
                    (fill_start_valid && fill_start_ready);

    // A sequencer request always beats the SCSI side for the same cycle
    assign inc_fifo = fill_inc || (!n_rififo && !drain_dec);
    assign dec_fifo = drain_dec || (!n_rdfifo && !fill_inc);

    always_comb begin
        state_nxt = state;
        breq      = 1'b0;
        bgack     = 1'b0;
        case (state)
            cpu_dma_pkg::ctl_idle: begin
                if (dma_ena && dma_dir && fifo_full) begin
                    state_nxt = cpu_dma_pkg::ctl_drain_req; // FIFO full, push it to memory
                end else if (dma_ena && !dma_dir && fifo_empty && !n_dreq) begin
                    state_nxt = cpu_dma_pkg::ctl_fill_req;  // SCSI side wants data
                end
            end
            cpu_dma_pkg::ctl_drain_req, cpu_dma_pkg::ctl_fill_req: begin
                breq  = 1'b1;
                bgack = bus_won; // Acknowledge in the same cycle the grant lands
                if (bus_won) state_nxt = cpu_dma_pkg::ctl_own;
            end
            cpu_dma_pkg::ctl_own: begin
                bgack = 1'b1;
                if (dispatched && seq_done) state_nxt = cpu_dma_pkg::ctl_letgo;
            end
            cpu_dma_pkg::ctl_letgo: begin
                bgack     = 1'b1; // One extra cycle so the last strobes release cleanly
                state_nxt = cpu_dma_pkg::ctl_idle;
            end
            default: state_nxt = cpu_dma_pkg::ctl_idle;
        endcase
    end

    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            state      <= cpu_dma_pkg::ctl_idle;
            dir_drain  <= 1'b0;
            dispatched <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == cpu_dma_pkg::ctl_idle) dir_drain <= dma_dir; // Frozen once we leave idle
            if (accept) begin
                dispatched <= 1'b1;
            end else if (state == cpu_dma_pkg::ctl_letgo) begin
                dispatched <= 1'b0;
            end
        end
    end

    // Only one sequencer runs per tenure, so the count requests never collide
    a_one_counter_side: assert property (@(posedge CLK90) disable iff (!nRESET)
        !(drain_dec && fill_inc));

    // A start only goes out once both sequencers are back in idle
    a_start_seqs_idle: assert property (@(posedge CLK90) disable iff (!nRESET)
        (drain_start_valid || fill_start_valid) |-> drain_start_ready && fill_start_ready);

endmodule

// File: rtl/fifo_drain_seq.sv
// Drain sequencer running CPU write cycles from the FIFO, bridging the second word on 16-bit ports
`timescale 1ns/1ps

module fifo_drain_seq (
    input  logic                CLK90,
    input  logic                nRESET,
    input  logic                start_valid,
    input  logic                fifo_empty,
    input  logic                n_sterm,
    input  logic                dsack,
    input  cpu_dma_pkg::dsack_t n_dsack,
    output logic                start_ready,
    output logic                done,
    output logic                dec_req,
    output logic                pas,
    output logic                pds,
    output logic                size1,
    output logic                f2cpu_h,
    output logic                f2cpu_l,
    output logic                bridge_out
);

    cpu_dma_pkg::drain_state_e state;
    cpu_dma_pkg::drain_state_e state_nxt;
    cpu_dma_pkg::term_e        term;
    logic                      in_long; // Full longword cycle in flight
    logic                      in_word; // Second word going out over the bridge

    assign term    = cpu_dma_pkg::term_classify(n_sterm, dsack, n_dsack);
    assign in_long = state inside {cpu_dma_pkg::dr_start, cpu_dma_pkg::dr_strobe,
                                   cpu_dma_pkg::dr_wait};
    assign in_word = state inside {cpu_dma_pkg::dr_word_start, cpu_dma_pkg::dr_word_strobe,
                                   cpu_dma_pkg::dr_word_wait};
    assign start_ready = (state == cpu_dma_pkg::dr_idle);
    assign size1       = in_word; // Word-sized transfer for the bridged half
    assign bridge_out  = in_word; // Low FIFO half steered onto D16-D31

    always_comb begin
        state_nxt = state;
        done      = 1'b0;
        dec_req   = 1'b0;
        pas       = 1'b0;
        pds       = 1'b0;
        f2cpu_h   = in_long;
        f2cpu_l   = in_long || in_word;
        case (state)
            cpu_dma_pkg::dr_idle: begin
                if (start_valid) state_nxt = cpu_dma_pkg::dr_start;
            end
            cpu_dma_pkg::dr_start, cpu_dma_pkg::dr_word_start: begin
                pas       = 1'b1; // Address phase only
                state_nxt = in_word ? cpu_dma_pkg::dr_word_strobe : cpu_dma_pkg::dr_strobe;
            end
            cpu_dma_pkg::dr_strobe, cpu_dma_pkg::dr_word_strobe: begin
                if (term == cpu_dma_pkg::term_32) begin
                    dec_req   = 1'b1; // Zero wait state finish
                    state_nxt = cpu_dma_pkg::dr_check;
                end else begin
                    pas       = 1'b1;
                    pds       = 1'b1;
                    state_nxt = in_word ? cpu_dma_pkg::dr_word_wait : cpu_dma_pkg::dr_wait;
                end
            end
            cpu_dma_pkg::dr_wait, cpu_dma_pkg::dr_word_wait: begin
                if (term == cpu_dma_pkg::term_32 || (in_word && term == cpu_dma_pkg::term_16)) begin
                    dec_req   = 1'b1; // Longword fully written
                    state_nxt = cpu_dma_pkg::dr_check;
                end else if (term == cpu_dma_pkg::term_16) begin
                    state_nxt = cpu_dma_pkg::dr_word_start; // Upper word taken, low word still due
                end else begin
                    pas = 1'b1; // Hold strobes through wait states
                    pds = 1'b1;
                end
            end
            cpu_dma_pkg::dr_check: begin
                if (fifo_empty) begin
                    done      = 1'b1;
                    state_nxt = cpu_dma_pkg::dr_idle;
                end else begin
                    pas       = 1'b1; // Next address goes out right away
                    f2cpu_h   = 1'b1;
                    f2cpu_l   = 1'b1;
                    state_nxt = cpu_dma_pkg::dr_strobe;
                end
            end
            default: state_nxt = cpu_dma_pkg::dr_idle;
        endcase
    end

    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) state <= cpu_dma_pkg::dr_idle;
        else state <= state_nxt;
    end

    // Byte ports are outside the supported set, so a wait must never see one
    a_no_byte_port: assert property (@(posedge CLK90) disable iff (!nRESET)
        (state inside {cpu_dma_pkg::dr_wait, cpu_dma_pkg::dr_word_wait})
        |-> term != cpu_dma_pkg::term_bad);

endmodule

// File: rtl/fifo_fill_seq.sv
// Fill sequencer running CPU read cycles into the FIFO, re-reading the odd word on 16-bit ports
`timescale 1ns/1ps

module fifo_fill_seq (
    input  logic                CLK90,
    input  logic                nRESET,
    input  logic                start_valid,
    input  logic                fifo_full,
    input  logic                n_sterm,
    input  logic                dsack,
    input  cpu_dma_pkg::dsack_t n_dsack,
    output logic                start_ready,
    output logic                done,
    output logic                inc_req,
    output logic                inc_ni,
    output logic                pas,
    output logic                pds,
    output logic                size1,
    output logic                plhw,
    output logic                pllw,
    output logic                die_h,
    output logic                die_l,
    output logic                bridge_in
);

    cpu_dma_pkg::fill_state_e state;
    cpu_dma_pkg::fill_state_e state_nxt;
    cpu_dma_pkg::term_e       term;
    logic                     in_odd; // Re-reading the odd word from a 16-bit port

    assign term   = cpu_dma_pkg::term_classify(n_sterm, dsack, n_dsack);
    assign in_odd = state inside {cpu_dma_pkg::fl_odd_start, cpu_dma_pkg::fl_odd_hold,
                                  cpu_dma_pkg::fl_odd_wait};
    assign start_ready = (state == cpu_dma_pkg::fl_idle);
    assign size1       = in_odd;
    assign bridge_in   = in_odd; // D16-D31 routed down to the low input half

    always_comb begin
        state_nxt = state;
        done      = 1'b0;
        inc_req   = 1'b0;
        inc_ni    = 1'b0;
        pas       = 1'b0;
        pds       = 1'b0;
        plhw      = 1'b0;
        pllw      = 1'b0;
        die_h     = in_odd; // High input stays enabled through the odd-word read
        die_l     = 1'b0;
        case (state)
            cpu_dma_pkg::fl_idle: begin
                if (start_valid) state_nxt = cpu_dma_pkg::fl_start;
            end
            cpu_dma_pkg::fl_start: begin
                {pas, pds, plhw, pllw, die_h, die_l} = '1;
                state_nxt = cpu_dma_pkg::fl_strobe;
            end
            cpu_dma_pkg::fl_strobe, cpu_dma_pkg::fl_wait: begin
                die_h = 1'b1;
                if (term == cpu_dma_pkg::term_32) begin
                    inc_req   = 1'b1; // Whole longword latched
                    die_l     = 1'b1;
                    state_nxt = cpu_dma_pkg::fl_next;
                end else if (state == cpu_dma_pkg::fl_wait && term == cpu_dma_pkg::term_16) begin
                    state_nxt = cpu_dma_pkg::fl_odd_start; // Only the high word arrived
                end else begin
                    {pas, pds, plhw, pllw, die_l} = '1; // Strobes held through wait states
                    state_nxt = cpu_dma_pkg::fl_wait;
                end
            end
            cpu_dma_pkg::fl_odd_start, cpu_dma_pkg::fl_odd_hold: begin
                {pas, pds, pllw} = '1;
                state_nxt = (state == cpu_dma_pkg::fl_odd_start) ? cpu_dma_pkg::fl_odd_hold
                                                                 : cpu_dma_pkg::fl_odd_wait;
            end
            cpu_dma_pkg::fl_odd_wait: begin
                if (term != cpu_dma_pkg::term_none) begin
                    inc_req   = 1'b1; // Second half latched, longword complete
                    state_nxt = cpu_dma_pkg::fl_next;
                end else begin
                    {pas, pds, pllw} = '1;
                end
            end
            cpu_dma_pkg::fl_next: begin
                inc_ni = 1'b1; // Advance the write pointer
                if (fifo_full) begin
                    done      = 1'b1;
                    state_nxt = cpu_dma_pkg::fl_idle;
                end else begin
                    {pas, pds, plhw, pllw, die_h, die_l} = '1;
                    state_nxt = cpu_dma_pkg::fl_strobe;
                end
            end
            default: state_nxt = cpu_dma_pkg::fl_idle;
        endcase
    end

    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) state <= cpu_dma_pkg::fl_idle;
        else state <= state_nxt;
    end

    // A byte port answering a read would leave half a longword in the FIFO
    a_no_byte_port: assert property (@(posedge CLK90) disable iff (!nRESET)
        (state inside {cpu_dma_pkg::fl_wait, cpu_dma_pkg::fl_odd_wait})
        |-> term != cpu_dma_pkg::term_bad);

endmodule

// File: rtl/cpu_dma_sm.sv
// CPU-side DMA bus master built from the bus controller and the drain and fill sequencers
`timescale 1ns/1ps

module cpu_dma_sm (
    input  logic                CLK90,
    input  logic                nRESET,
    input  logic                dma_ena,
    input  logic                dma_dir,
    input  logic                fifo_full,
    input  logic                fifo_empty,
    input  logic                n_dreq,
    input  logic                n_bgrant,
    input  logic                cycle_done,
    input  logic                n_rififo,
    input  logic                n_rdfifo,
    input  logic                n_sterm,
    input  logic                dsack,
    input  cpu_dma_pkg::dsack_t n_dsack,
    output logic                breq,
    output logic                bgack,
    output logic                pas,
    output logic                pds,
    output logic                size1,
    output logic                f2cpu_h,
    output logic                f2cpu_l,
    output logic                bridge_out,
    output logic                plhw,
    output logic                pllw,
    output logic                die_h,
    output logic                die_l,
    output logic                bridge_in,
    output logic                inc_fifo,
    output logic                dec_fifo,
    output logic                inc_ni
);

    logic drain_start_valid, drain_start_ready, drain_done, drain_dec;
    logic fill_start_valid, fill_start_ready, fill_done, fill_inc;
    logic dr_pas, dr_pds, dr_size1; // Drain side bus strobes
    logic fl_pas, fl_pds, fl_size1; // Fill side bus strobes

    // Only one sequencer is ever out of idle, so a plain OR merges the strobes
    assign pas   = dr_pas | fl_pas;
    assign pds   = dr_pds | fl_pds;
    assign size1 = dr_size1 | fl_size1;

    dma_bus_ctl u_ctl (
        .CLK90, .nRESET, .dma_ena, .dma_dir, .fifo_full, .fifo_empty, .n_dreq,
        .n_bgrant, .cycle_done, .n_rififo, .n_rdfifo,
        .drain_start_ready, .drain_done, .drain_dec,
        .fill_start_ready, .fill_done, .fill_inc,
        .breq, .bgack, .drain_start_valid, .fill_start_valid, .inc_fifo, .dec_fifo
    );

    fifo_drain_seq u_drain (
        .CLK90, .nRESET, .start_valid(drain_start_valid), .fifo_empty,
        .n_sterm, .dsack, .n_dsack,
        .start_ready(drain_start_ready), .done(drain_done), .dec_req(drain_dec),
        .pas(dr_pas), .pds(dr_pds), .size1(dr_size1), .f2cpu_h, .f2cpu_l, .bridge_out
    );

    fifo_fill_seq u_fill (
        .CLK90, .nRESET, .start_valid(fill_start_valid), .fifo_full,
        .n_sterm, .dsack, .n_dsack,
        .start_ready(fill_start_ready), .done(fill_done), .inc_req(fill_inc), .inc_ni,
        .pas(fl_pas), .pds(fl_pds), .size1(fl_size1), .plhw, .pllw, .die_h, .die_l,
        .bridge_in
    );

endmodule

// File: verif/cpu_bus_slave.sv
// Behavioral CPU bus slave that ends each address strobe with STERM or DSACK after set wait states
`timescale 1ns/1ps

module cpu_bus_slave (
    input  logic                CLK90,
    input  logic                nRESET,
    input  logic                pas,
    input  logic [1:0]          mode,    // 0 STERM, 1 DSACK on a 32-bit port, 2 DSACK on a 16-bit port
    input  logic [3:0]          waits,   // Wait states before the termination shows up
    output logic                n_sterm,
    output logic                dsack,
    output cpu_dma_pkg::dsack_t n_dsack
);

    localparam logic [1:0] mode_sterm = 2'd0;
    localparam logic [1:0] mode_d16   = 2'd2;

    logic       resp  = 1'b0;  // Termination being driven onto the bus
    logic [3:0] count = 4'd0;  // Cycles seen with the address strobe up

    assign n_sterm = !(resp && mode == mode_sterm);
    assign dsack   = resp && (mode != mode_sterm);  // DSACK lines are valid only with this
    assign n_dsack = !dsack ? 2'b11 : ((mode == mode_d16) ? 2'b01 : 2'b00); // DSACK1 alone on 16-bit

    // Termination is held until the master drops its address strobe
    always @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            resp  <= 1'b0;
            count <= 4'd0;
        end else if (!pas) begin
            resp  <= 1'b0;  // Cycle over, start counting again on the next strobe
            count <= 4'd0;
        end else if (count >= waits) begin
            resp <= 1'b1;
        end else begin
            count <= count + 4'd1;  // Still in wait states
        end
    end

endmodule

// File: verif/cpu_dma_sm_tb.sv
// Testbench for the CPU-side DMA bus master with drain and fill runs against a behavioral slave
`timescale 1ns/1ps

module cpu_dma_sm_tb;

    localparam int clk_period_ns  = 10;
    localparam int fifo_depth     = 8;
    localparam int n_rows         = 6;
    localparam int max_row_cycles = 200;  // A 16-bit drain with wait states needs about 60
    localparam int timeout_ns     = (n_rows * max_row_cycles + 40) * clk_period_ns;
    localparam int c_dir = 0;    // 1 drains the FIFO to the CPU, 0 fills it
    localparam int c_mode = 1;   // 0 STERM, 1 DSACK 32-bit, 2 DSACK 16-bit
    localparam int c_waits = 2;
    localparam int c_rdff = 3;   // Level held on n_rdfifo through the row
    localparam int c_inc = 4;    // Expected inc_fifo, dec_fifo and inc_ni pulses follow
    localparam int c_dec = 5;
    localparam int c_ni = 6;
    localparam int c_pas = 7;    // Address strobes, one per bus cycle
    localparam int c_brg = 8;    // Bus cycles steered through a bridge

    string row_name [n_rows] = '{"drain_sterm", "drain_dsack32", "drain_dsack16",
                                 "fill_dsack32", "fill_dsack16", "fill_merge"};
    int rows [n_rows][9] = '{
        '{1, 0, 0, 1, 0, 8, 0,  8, 0},
        '{1, 1, 2, 1, 0, 8, 0,  8, 0},
        '{1, 2, 1, 1, 0, 8, 0, 16, 8},  // Every entry needs a bridged second word
        '{0, 1, 1, 1, 8, 0, 8,  8, 0},
        '{0, 2, 0, 1, 8, 0, 8, 16, 8},  // Odd word re-read through the input bridge
        '{0, 0, 1, 0, 8, 0, 8,  8, 0}   // SCSI side strobing reads during the whole fill
    };

    logic CLK90 = 1'b0;
    logic nRESET = 1'b0;
    logic dma_ena = 1'b0;
    logic dma_dir = 1'b0;
    logic n_dreq = 1'b1;
    logic n_bgrant = 1'b1;
    logic cycle_done = 1'b1;  // Previous bus owner is always off the bus
    logic n_rififo = 1'b1;
    logic n_rdfifo = 1'b1;
    logic fifo_full, fifo_empty, n_sterm, dsack;
    cpu_dma_pkg::dsack_t n_dsack;
    logic breq, bgack, pas, pds, size1, inc_fifo, dec_fifo, inc_ni;
    logic f2cpu_h, f2cpu_l, bridge_out, plhw, pllw, die_h, die_l, bridge_in;
    logic [1:0] slave_mode = 2'd0;
    logic [3:0] slave_waits = 4'd0;
    logic load = 1'b0;  // Preloads the FIFO level before a row
    int load_val = 0;
    int fifo_count = 0;
    int unsigned grant_wait = 0;
    logic pas_q = 1'b0;
    int inc_cnt = 0, dec_cnt = 0, ni_cnt = 0, pas_cnt = 0, brg_cnt = 0;
    string cur_name = "reset_idle";

    cpu_dma_sm uut (
        .CLK90, .nRESET, .dma_ena, .dma_dir, .fifo_full, .fifo_empty, .n_dreq, .n_bgrant,
        .cycle_done, .n_rififo, .n_rdfifo, .n_sterm, .dsack, .n_dsack, .breq, .bgack, .pas,
        .pds, .size1, .f2cpu_h, .f2cpu_l, .bridge_out, .plhw, .pllw, .die_h, .die_l,
        .bridge_in, .inc_fifo, .dec_fifo, .inc_ni
    );

    cpu_bus_slave u_slave (.CLK90, .nRESET, .pas, .mode(slave_mode), .waits(slave_waits),
                           .n_sterm, .dsack, .n_dsack);

    initial forever #(clk_period_ns / 2) CLK90 = ~CLK90;

    initial begin
        #(timeout_ns);
        $display("Timeout: the DMA runs did not finish within %0d ns", timeout_ns);
        $display("Verification failed");
        $fatal(1);
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    assign fifo_full  = (fifo_count == fifo_depth);
    assign fifo_empty = (fifo_count == 0);

    // A held n_rdfifo stands for SCSI reads that never leave the level model
    always @(posedge CLK90) begin
        if (load) fifo_count <= load_val;
        else if (nRESET) fifo_count <= fifo_count + (inc_fifo ? 1 : 0)
                                       - ((dec_fifo && n_rdfifo) ? 1 : 0);
    end

    // Arbiter grants 0 to 3 cycles after breq and withdraws once the request drops
    always @(posedge CLK90) begin
        if (!nRESET || !breq) begin
            n_bgrant   <= 1'b1;
            grant_wait <= $urandom % 4;
        end else if (grant_wait == 0) begin
            n_bgrant <= 1'b0;
        end else begin
            grant_wait <= grant_wait - 1;
        end
    end

    always @(posedge CLK90) begin
        if (nRESET) begin
            pas_q <= pas;
            if (inc_fifo) inc_cnt <= inc_cnt + 1;
            if (dec_fifo && n_rdfifo) dec_cnt <= dec_cnt + 1;  // DMA side decrements only
            if (inc_ni) ni_cnt <= ni_cnt + 1;
            if (pas && !pas_q) begin
                pas_cnt <= pas_cnt + 1;  // New bus cycle
                if (bridge_out || bridge_in) brg_cnt <= brg_cnt + 1;
            end
            // With the drain side idle the SCSI read must yield to every fill increment
            if (!n_rdfifo) check_value({cur_name, " merge"}, int'(!inc_fifo), int'(dec_fifo));
            if (pas && dma_dir) begin
                // The bridged word only drives the low FIFO half
                check_value({cur_name, " f2cpu"}, int'({!bridge_out, 1'b1}),
                            int'({f2cpu_h, f2cpu_l}));
            end
            if (pas && !dma_dir) begin
                // Odd-word reads latch only the low half through the high input
                check_value({cur_name, " fill_ctl"}, int'({3'b111, {2{!bridge_in}}}),
                            int'({pds, pllw, die_h, plhw, die_l}));
            end
            if (!pas) check_value({cur_name, " pds"}, 0, int'(pds));  // Data strobe needs AS
            check_value({cur_name, " size1"}, int'(bridge_out || bridge_in), int'(size1));
        end
    end

    task automatic run_row(input int r);
        int inc0, dec0, ni0, pas0, brg0;
        logic drain;
        drain    = (rows[r][c_dir] != 0);
        cur_name = row_name[r];
        @(posedge CLK90);
        dma_dir     <= drain;
        n_dreq      <= drain;  // SCSI side asks for data only when filling
        n_rdfifo    <= (rows[r][c_rdff] != 0);
        slave_mode  <= 2'(rows[r][c_mode]);
        slave_waits <= 4'(rows[r][c_waits]);
        load        <= 1'b1;
        load_val    <= drain ? fifo_depth : 0;
        @(posedge CLK90);
        load <= 1'b0;
        @(posedge CLK90);
        inc0 = inc_cnt;
        dec0 = dec_cnt;
        ni0  = ni_cnt;
        pas0 = pas_cnt;
        brg0 = brg_cnt;
        dma_ena <= 1'b1;
        do @(posedge CLK90); while (!bgack);
        do @(posedge CLK90); while (bgack);  // Release marks the end of the tenure
        dma_ena <= 1'b0;
        check_value({cur_name, " end_flag"}, 1, int'(drain ? fifo_empty : fifo_full));
        @(posedge CLK90);
        check_value({cur_name, " inc_fifo"}, rows[r][c_inc], inc_cnt - inc0);
        check_value({cur_name, " dec_fifo"}, rows[r][c_dec], dec_cnt - dec0);
        check_value({cur_name, " inc_ni"}, rows[r][c_ni], ni_cnt - ni0);
        check_value({cur_name, " pas"}, rows[r][c_pas], pas_cnt - pas0);
        check_value({cur_name, " bridged"}, rows[r][c_brg], brg_cnt - brg0);
        check_value({cur_name, " level"}, drain ? 0 : fifo_depth, fifo_count);
        n_rdfifo <= 1'b1;
    endtask

    initial begin
        void'($urandom(55));
        repeat (2) @(posedge CLK90);
        nRESET <= 1'b1;
        repeat (20) begin
            @(posedge CLK90);
            check_value(cur_name, 0, int'({breq, bgack, pas, inc_fifo, dec_fifo}));
        end
        for (int r = 0; r < n_rows; r++) run_row(r);
        $display("Verification passed");
        $finish;
    end

endmodule

// File: cpu_dma_sm.f
+incdir+rtl
rtl/cpu_dma_pkg.sv
rtl/dma_bus_ctl.sv
rtl/fifo_drain_seq.sv
rtl/fifo_fill_seq.sv
rtl/cpu_dma_sm.sv
verif/cpu_bus_slave.sv
verif/cpu_dma_sm_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = cpu_dma_sm_tb
FILELIST  = cpu_dma_sm.f
PASS_MSG  = Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
